// ==== verilog/xfcp_defs.svh ====
// Port count, widths and command codes of the control core
`ifndef XFCP_DEFS_SVH
`define XFCP_DEFS_SVH

// Endpoints behind the router and stream byte width
`define XFCP_PORT_COUNT 2
`define XFCP_DATA_W     8

// Wishbone bus of each RAM endpoint
`define WB_ADDR_W 8
`define WB_DATA_W 32

// Request codes, the response code is the request plus one
`define XFCP_CMD_READ       8'h10
`define XFCP_CMD_READ_RESP  8'h11
`define XFCP_CMD_WRITE      8'h12
`define XFCP_CMD_WRITE_RESP 8'h13

`endif

// ==== verilog/xfcp_pkg.sv ====
// Shared types of the control core
// Stream beat, beat tagged with its source port
// Wishbone request and response bundles
`include "xfcp_defs.svh"

package xfcp_pkg;

    typedef logic [$clog2(`XFCP_PORT_COUNT)-1:0] xfcp_port_t;

    typedef struct packed {
        logic [`XFCP_DATA_W-1:0] data;
        logic                    last;
        logic                    user;
    } xfcp_beat_t;

    typedef struct packed {
        xfcp_beat_t beat;
        xfcp_port_t port;
    } xfcp_tagged_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic                  we;
        logic                  stb;
        logic                  cyc;
    } wb_req_t;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  ack;
    } wb_resp_t;

endpackage

// ==== verilog/stream_skid.sv ====
// Two-entry skid buffer for a valid/ready stream of any payload type
module stream_skid #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  T     s_data_i,
    input  logic s_valid_i,
    output logic s_ready_o,
    output T     m_data_o,
    output logic m_valid_o,
    input  logic m_ready_i
);
    T           mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic [1:0] count_next;
    logic       ready_q;
    logic       push;
    logic       pop;

    assign push = s_valid_i && ready_q;
    assign pop = m_valid_o && m_ready_i;
    assign count_next = count_q + {1'b0, push} - {1'b0, pop};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q <= 2'd0;
            ready_q <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ push;
            rd_ptr_q <= rd_ptr_q ^ pop;
            count_q <= count_next;
            // Registered so that ready never depends on m_ready_i
            ready_q <= (count_next != 2'd2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_data_i;
        end
    end

    assign s_ready_o = ready_q;
    assign m_data_o = mem_q[rd_ptr_q];
    assign m_valid_o = (count_q != 2'd0);

endmodule

// ==== verilog/xfcp_route.sv ====
// Request router
// Strips the leading port byte and steers the rest of the packet
// to one endpoint, or swallows it when the port is out of range
`include "xfcp_defs.svh"

module xfcp_route (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  xfcp_pkg::xfcp_beat_t                         s_beat_i,
    input  logic                                         s_valid_i,
    output logic                                         s_ready_o,
    output xfcp_pkg::xfcp_beat_t [`XFCP_PORT_COUNT-1:0] m_beat_o,
    output logic [`XFCP_PORT_COUNT-1:0]                  m_valid_o,
    input  logic [`XFCP_PORT_COUNT-1:0]                  m_ready_i
);
    import xfcp_pkg::*;

    logic       in_pkt_q;
    logic       drop_q;
    xfcp_port_t dest_q;
    logic       xfer;

    // Port byte is always taken, later beats wait for the endpoint
    assign s_ready_o = !in_pkt_q || drop_q || m_ready_i[dest_q];
    assign xfer = s_valid_i && s_ready_o;

    always_comb begin
        for (int i = 0; i < `XFCP_PORT_COUNT; i++) begin
            m_beat_o[i] = s_beat_i;
            m_valid_o[i] = s_valid_i && in_pkt_q && !drop_q && (dest_q == xfcp_port_t'(i));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_pkt_q <= 1'b0;
            drop_q <= 1'b0;
            dest_q <= '0;
        end else if (xfer) begin
            if (!in_pkt_q) begin
                // A packet that is only a port byte ends here
                in_pkt_q <= !s_beat_i.last;
                drop_q <= (s_beat_i.data >= `XFCP_PORT_COUNT);
                dest_q <= xfcp_port_t'(s_beat_i.data);
            end else if (s_beat_i.last) begin
                in_pkt_q <= 1'b0;
                drop_q <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/xfcp_wb_access.sv ====
// Wishbone access endpoint
// Parses one read or write request, runs a single Wishbone cycle
// and sends back the response packet
`include "xfcp_defs.svh"

module xfcp_wb_access (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  xfcp_pkg::xfcp_beat_t s_beat_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,
    output xfcp_pkg::xfcp_beat_t m_beat_o,
    output logic                 m_valid_o,
    input  logic                 m_ready_i,
    output xfcp_pkg::wb_req_t    wb_req_o,
    input  xfcp_pkg::wb_resp_t   wb_resp_i
);
    typedef enum logic [2:0] {
        ST_CMD,
        ST_ADDR,
        ST_DATA,
        ST_DROP,
        ST_WB,
        ST_RESP
    } state_t;

    state_t                state_q;
    state_t                drop_st;
    logic [1:0]            byte_cnt_q;
    logic [2:0]            resp_idx_q;
    logic [1:0]            byte_sel;
    logic [7:0]            cmd_q;
    logic [`WB_ADDR_W-1:0] addr_q;
    logic [`WB_DATA_W-1:0] data_q;
    logic                  is_write;
    logic                  xfer;

    assign is_write = (cmd_q == `XFCP_CMD_WRITE);
    assign s_ready_o = (state_q == ST_CMD) || (state_q == ST_ADDR) ||
                       (state_q == ST_DATA) || (state_q == ST_DROP);
    assign xfer = s_valid_i && s_ready_o;
    // Bad request, skip what is left of the packet
    assign drop_st = s_beat_i.last ? ST_CMD : ST_DROP;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_CMD;
            byte_cnt_q <= 2'd0;
            resp_idx_q <= 3'd0;
        end else begin
            case (state_q)
                ST_CMD: if (xfer) begin
                    if (s_beat_i.user || s_beat_i.last ||
                        (s_beat_i.data != `XFCP_CMD_READ && s_beat_i.data != `XFCP_CMD_WRITE)) begin
                        state_q <= drop_st;
                    end else begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: if (xfer) begin
                    byte_cnt_q <= 2'd0;
                    if (s_beat_i.user) state_q <= drop_st;
                    else if (!is_write) state_q <= s_beat_i.last ? ST_WB : ST_DROP;
                    else state_q <= s_beat_i.last ? ST_CMD : ST_DATA;
                end
                ST_DATA: if (xfer) begin
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                    if (s_beat_i.user) state_q <= drop_st;
                    else if (byte_cnt_q == 2'd3) state_q <= s_beat_i.last ? ST_WB : ST_DROP;
                    else if (s_beat_i.last) state_q <= ST_CMD;
                end
                ST_DROP: if (xfer && s_beat_i.last) state_q <= ST_CMD;
                ST_WB: if (wb_resp_i.ack) begin
                    resp_idx_q <= 3'd0;
                    state_q <= ST_RESP;
                end
                ST_RESP: if (m_ready_i) begin
                    resp_idx_q <= resp_idx_q + 3'd1;
                    if (m_beat_o.last) state_q <= ST_CMD;
                end
                default: state_q <= ST_CMD;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && state_q == ST_CMD) cmd_q <= s_beat_i.data;
        if (xfer && state_q == ST_ADDR) addr_q <= s_beat_i.data;
        if (xfer && state_q == ST_DATA) data_q[byte_cnt_q*8 +: 8] <= s_beat_i.data;
        if (state_q == ST_WB && wb_resp_i.ack && !is_write) data_q <= wb_resp_i.dat;
    end

    // Response index 2..5 walks the data bytes LSB first
    assign byte_sel = resp_idx_q[1:0] - 2'd2;

    always_comb begin
        m_beat_o.user = 1'b0;
        m_beat_o.last = is_write ? (resp_idx_q == 3'd1) : (resp_idx_q == 3'd5);
        case (resp_idx_q)
            3'd0: m_beat_o.data = cmd_q + 8'd1;
            3'd1: m_beat_o.data = addr_q;
            default: m_beat_o.data = data_q[byte_sel*8 +: 8];
        endcase
    end

    assign m_valid_o = (state_q == ST_RESP);
    assign wb_req_o = '{adr: addr_q, dat: data_q, we: is_write,
                        stb: (state_q == ST_WB), cyc: (state_q == ST_WB)};

endmodule

// ==== verilog/wb_ram.sv ====
// Single-ported Wishbone RAM, 32-bit words
// Read data is registered and ack follows stb by one cycle
`include "xfcp_defs.svh"

module wb_ram (
    input  logic               clk_i,
    input  xfcp_pkg::wb_req_t  wb_req_i,
    output xfcp_pkg::wb_resp_t wb_resp_o
);
    logic [`WB_DATA_W-1:0] mem_q [2**`WB_ADDR_W];
    logic [`WB_DATA_W-1:0] rd_data_q;
    logic                  ack_q;

    always_ff @(posedge clk_i) begin
        if (wb_req_i.stb && wb_req_i.we) begin
            mem_q[wb_req_i.adr] <= wb_req_i.dat;
        end
        rd_data_q <= mem_q[wb_req_i.adr];
    end

    // One ack per access, stb is still high on the ack cycle
    always_ff @(posedge clk_i) begin
        ack_q <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
    end

    assign wb_resp_o = '{dat: rd_data_q, ack: ack_q};

endmodule

// ==== verilog/xfcp_merge.sv ====
// Response merge
// Round-robin choice of one endpoint per packet, tagged skid buffer,
// then the port byte goes out ahead of each response
`include "xfcp_defs.svh"

module xfcp_merge (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  xfcp_pkg::xfcp_beat_t [`XFCP_PORT_COUNT-1:0] s_beat_i,
    input  logic [`XFCP_PORT_COUNT-1:0]                  s_valid_i,
    output logic [`XFCP_PORT_COUNT-1:0]                  s_ready_o,
    output xfcp_pkg::xfcp_beat_t                         m_beat_o,
    output logic                                         m_valid_o,
    input  logic                                         m_ready_i
);
    import xfcp_pkg::*;

    logic         active_q;
    xfcp_port_t   last_q;
    xfcp_port_t   grant;
    xfcp_port_t   cur;
    xfcp_tagged_t arb_data;
    logic         arb_valid;
    logic         arb_ready;
    xfcp_tagged_t t_data;
    logic         t_valid;
    logic         t_ready;
    logic         pfx_done_q;

    // Lowest offset after the last winner has priority
    always_comb begin
        grant = last_q;
        for (int k = `XFCP_PORT_COUNT; k >= 1; k--) begin
            if (s_valid_i[(int'(last_q) + k) % `XFCP_PORT_COUNT]) begin
                grant = xfcp_port_t'((int'(last_q) + k) % `XFCP_PORT_COUNT);
            end
        end
    end

    assign cur = active_q ? last_q : grant;
    assign arb_data = '{beat: s_beat_i[cur], port: cur};
    assign arb_valid = s_valid_i[cur];

    always_comb begin
        s_ready_o = '0;
        s_ready_o[cur] = arb_ready;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            last_q <= '0;
        end else if (arb_valid && arb_ready) begin
            active_q <= !arb_data.beat.last;
            last_q <= cur;
        end
    end

    stream_skid #(
        .T(xfcp_tagged_t)
    ) u_skid (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_data_i  (arb_data),
        .s_valid_i (arb_valid),
        .s_ready_o (arb_ready),
        .m_data_o  (t_data),
        .m_valid_o (t_valid),
        .m_ready_i (t_ready)
    );

    // Port byte first, taken from the tag of the packet's first beat
    always_comb begin
        m_beat_o = t_data.beat;
        if (!pfx_done_q) begin
            m_beat_o = '{data: `XFCP_DATA_W'(t_data.port), last: 1'b0, user: 1'b0};
        end
    end

    assign m_valid_o = t_valid;
    assign t_ready = pfx_done_q && m_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pfx_done_q <= 1'b0;
        end else if (m_valid_o && m_ready_i) begin
            pfx_done_q <= !pfx_done_q || !t_data.beat.last;
        end
    end

endmodule

// ==== verilog/xfcp_core.sv ====
// Control core top level
// Input skid buffer, router, one Wishbone endpoint and RAM per port,
// and the response merge back upstream
`include "xfcp_defs.svh"

module xfcp_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  xfcp_pkg::xfcp_beat_t in_beat_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    output xfcp_pkg::xfcp_beat_t out_beat_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i
);
    import xfcp_pkg::*;

    xfcp_beat_t                         skid_beat;
    logic                               skid_valid;
    logic                               skid_ready;
    xfcp_beat_t [`XFCP_PORT_COUNT-1:0] req_beat;
    logic [`XFCP_PORT_COUNT-1:0]        req_valid;
    logic [`XFCP_PORT_COUNT-1:0]        req_ready;
    xfcp_beat_t [`XFCP_PORT_COUNT-1:0] resp_beat;
    logic [`XFCP_PORT_COUNT-1:0]        resp_valid;
    logic [`XFCP_PORT_COUNT-1:0]        resp_ready;
    wb_req_t                            wb_req [`XFCP_PORT_COUNT];
    wb_resp_t                           wb_resp [`XFCP_PORT_COUNT];

    stream_skid #(
        .T(xfcp_beat_t)
    ) u_in_skid (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_data_i  (in_beat_i),
        .s_valid_i (in_valid_i),
        .s_ready_o (in_ready_o),
        .m_data_o  (skid_beat),
        .m_valid_o (skid_valid),
        .m_ready_i (skid_ready)
    );

    xfcp_route u_route (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_beat_i  (skid_beat),
        .s_valid_i (skid_valid),
        .s_ready_o (skid_ready),
        .m_beat_o  (req_beat),
        .m_valid_o (req_valid),
        .m_ready_i (req_ready)
    );

    for (genvar i = 0; i < `XFCP_PORT_COUNT; i++) begin : g_port
        xfcp_wb_access u_wb_access (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .s_beat_i  (req_beat[i]),
            .s_valid_i (req_valid[i]),
            .s_ready_o (req_ready[i]),
            .m_beat_o  (resp_beat[i]),
            .m_valid_o (resp_valid[i]),
            .m_ready_i (resp_ready[i]),
            .wb_req_o  (wb_req[i]),
            .wb_resp_i (wb_resp[i])
        );

        wb_ram u_ram (
            .clk_i     (clk_i),
            .wb_req_i  (wb_req[i]),
            .wb_resp_o (wb_resp[i])
        );
    end

    xfcp_merge u_merge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_beat_i  (resp_beat),
        .s_valid_i (resp_valid),
        .s_ready_o (resp_ready),
        .m_beat_o  (out_beat_o),
        .m_valid_o (out_valid_o),
        .m_ready_i (out_ready_i)
    );

endmodule

// ==== verification/tb_clock.sv ====
// Free-running testbench clock
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// ==== verification/xfcp_properties.sv ====
// Concurrent checks on the upstream handshakes of the control core
module xfcp_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 in_valid_i,
    input logic                 in_ready_i,
    input xfcp_pkg::xfcp_beat_t out_beat_i,
    input logic                 out_valid_i,
    input logic                 out_ready_i
);
    int fail_cnt = 0;

    a_out_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
        else begin
            fail_cnt++;
            $error("out_valid high while in reset");
        end

    // Stalled response beat must hold until taken
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
        else begin
            fail_cnt++;
            $error("out_valid dropped or out beat changed while out_ready was low");
        end

    a_no_in_xfer_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> !(in_valid_i && in_ready_i))
        else begin
            fail_cnt++;
            $error("input beat accepted while in reset");
        end

endmodule

// ==== verification/xfcp_monitor.sv ====
// Response checker for the control core
// Holds the expected packets queued by the stimulus, matches each
// received packet by its port byte and compares it byte by byte
`include "xfcp_defs.svh"

module xfcp_monitor (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  xfcp_pkg::xfcp_beat_t        beat_i,
    input  logic                        valid_i,
    input  logic                        ready_i,
    input  logic                        exp_push_i,
    input  logic [127:0]                exp_name_i,
    input  logic [3:0]                  exp_len_i,
    input  logic [55:0]                 exp_data_i,
    input  logic                        end_check_i,
    output logic [`XFCP_PORT_COUNT-1:0] busy_o,
    output int                          errors_o
);
    typedef struct packed {
        logic [127:0] name;
        logic [3:0]   len;
        logic [55:0]  data;
    } exp_t;

    exp_t                        exp_q [$];
    logic [7:0]                  rx [8];
    int                          rx_len;
    logic [`XFCP_PORT_COUNT-1:0] busy;

    // Bytes are packed first byte highest
    function automatic logic [7:0] exp_byte(input exp_t e, input int b);
        return e.data[(int'(e.len) - 1 - b) * 8 +: 8];
    endfunction

    task automatic check_packet();
        int   idx;
        exp_t e;
        idx = -1;
        foreach (exp_q[k]) begin
            if (idx < 0 && exp_byte(exp_q[k], 0) == rx[0]) begin
                idx = k;
            end
        end
        if (idx < 0) begin
            $display("unexpected response packet of %0d bytes for port byte %0d", rx_len, rx[0]);
            errors_o++;
        end else begin
            e = exp_q[idx];
            exp_q.delete(idx);
            if (rx_len != int'(e.len)) begin
                $display("mismatch %0s length expected %0d actual %0d", e.name, e.len, rx_len);
                errors_o++;
            end
            for (int b = 0; b < rx_len && b < int'(e.len) && b < 8; b++) begin
                if (rx[b] !== exp_byte(e, b)) begin
                    $display("mismatch %0s byte %0d expected %02h actual %02h",
                             e.name, b, exp_byte(e, b), rx[b]);
                    errors_o++;
                end
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_len = 0;
            errors_o = 0;
            busy_o = '0;
        end else begin
            if (exp_push_i) begin
                exp_q.push_back('{name: exp_name_i, len: exp_len_i, data: exp_data_i});
            end
            if (valid_i && ready_i) begin
                if (beat_i.user) begin
                    $display("response beat carries the error flag");
                    errors_o++;
                end
                if (rx_len < 8) begin
                    rx[rx_len] = beat_i.data;
                end
                rx_len++;
                if (beat_i.last) begin
                    check_packet();
                    rx_len = 0;
                end
            end
            if (end_check_i) begin
                foreach (exp_q[k]) begin
                    $display("missing response for test %0s on port %0d",
                             exp_q[k].name, exp_byte(exp_q[k], 0));
                    errors_o++;
                end
                exp_q.delete();
                if (rx_len != 0) begin
                    $display("response packet cut off after %0d bytes", rx_len);
                    errors_o++;
                end
            end
            busy = '0;
            foreach (exp_q[k]) begin
                busy[exp_byte(exp_q[k], 0)] = 1'b1;
            end
            busy_o = busy;
        end
    end

endmodule

// ==== verification/tb_xfcp_core.sv ====
// Testbench top for the control core
// Request table and stimulus loop, random out_ready, run timeout
`include "xfcp_defs.svh"

module tb_xfcp_core;
    import xfcp_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int DRIVE_DLY = 5;

    logic                        clk;
    logic                        rst_n;
    xfcp_beat_t                  in_beat;
    logic                        in_valid;
    logic                        in_ready;
    xfcp_beat_t                  out_beat;
    logic                        out_valid;
    logic                        out_ready = 1'b0;
    logic                        exp_push;
    logic [127:0]                exp_name;
    logic [3:0]                  exp_len;
    logic [55:0]                 exp_data;
    logic                        end_check;
    logic [`XFCP_PORT_COUNT-1:0] busy;
    int                          mon_errors;
    integer                      seed = 32'hcb226d57;
    int                          cycles = 0;
    int                          n_tests = 0;
    int                          total;

    // Table of requests and expected responses, bytes packed first byte highest
    logic [127:0] t_name [MAX_TESTS];
    int           t_len [MAX_TESTS];
    logic [55:0]  t_req [MAX_TESTS];
    int           t_user [MAX_TESTS];
    int           t_exp_len [MAX_TESTS];
    logic [55:0]  t_exp [MAX_TESTS];

    tb_clock #(.PERIOD(40)) u_clock (.clk_o(clk));

    xfcp_core u_xfcp_core (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_beat_i   (in_beat),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_beat_o  (out_beat),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    xfcp_monitor u_monitor (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .beat_i      (out_beat),
        .valid_i     (out_valid),
        .ready_i     (out_ready),
        .exp_push_i  (exp_push),
        .exp_name_i  (exp_name),
        .exp_len_i   (exp_len),
        .exp_data_i  (exp_data),
        .end_check_i (end_check),
        .busy_o      (busy),
        .errors_o    (mon_errors)
    );

    bind xfcp_core xfcp_properties u_properties (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_i  (in_ready_o),
        .out_beat_i  (out_beat_o),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    // Data words travel least significant byte first
    function automatic logic [31:0] le_bytes(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    task automatic add_entry(input logic [127:0] name, input int len, input logic [55:0] req,
                             input int user_pos, input int exp_len_in, input logic [55:0] exp);
        t_name[n_tests] = name;
        t_len[n_tests] = len;
        t_req[n_tests] = req;
        t_user[n_tests] = user_pos;
        t_exp_len[n_tests] = exp_len_in;
        t_exp[n_tests] = exp;
        n_tests++;
    endtask

    task automatic add_write(input logic [127:0] name, input logic [7:0] port,
                             input logic [7:0] addr, input logic [31:0] word);
        add_entry(name, 7, {port, `XFCP_CMD_WRITE, addr, le_bytes(word)}, -1,
                  3, {32'd0, port, `XFCP_CMD_WRITE_RESP, addr});
    endtask

    task automatic add_read(input logic [127:0] name, input logic [7:0] port,
                            input logic [7:0] addr, input logic [31:0] word);
        add_entry(name, 3, {32'd0, port, `XFCP_CMD_READ, addr}, -1,
                  7, {port, `XFCP_CMD_READ_RESP, addr, le_bytes(word)});
    endtask

    task automatic build_table();
        add_write("wr_p0_a05", 8'd0, 8'h05, 32'h1234_5678);
        add_read("rd_p0_a05", 8'd0, 8'h05, 32'h1234_5678);
        add_write("wr_p0_a20", 8'd0, 8'h20, 32'ha5a5_0f0f);
        add_write("wr_p1_a20", 8'd1, 8'h20, 32'h5a5a_f0f0);
        add_read("rd_p0_a20", 8'd0, 8'h20, 32'ha5a5_0f0f);
        add_read("rd_p1_a20", 8'd1, 8'h20, 32'h5a5a_f0f0);
        add_entry("bad_port", 3, {32'd0, 8'd5, `XFCP_CMD_READ, 8'h05}, -1, 0, '0);
        add_read("rd_after_port", 8'd0, 8'h05, 32'h1234_5678);
        add_entry("bad_cmd", 3, {32'd0, 8'd1, 8'h20, 8'h20}, -1, 0, '0);
        add_read("rd_after_cmd", 8'd1, 8'h20, 32'h5a5a_f0f0);
        add_entry("port_only", 1, {48'd0, 8'd0}, -1, 0, '0);
        add_entry("wr_user", 7, {8'd0, `XFCP_CMD_WRITE, 8'h05, le_bytes(32'hffff_ffff)},
                  4, 0, '0);
        add_entry("wr_short", 6, {8'd0, 8'd0, `XFCP_CMD_WRITE, 8'h05, 24'heeeeee}, -1, 0, '0);
        add_read("rd_after_bad", 8'd0, 8'h05, 32'h1234_5678);
        add_write("alt_wr_p0", 8'd0, 8'h30, 32'h0102_0304);
        add_write("alt_wr_p1", 8'd1, 8'h30, 32'hf1f2_f3f4);
        add_read("alt_rd_p0", 8'd0, 8'h30, 32'h0102_0304);
        add_read("alt_rd_p1", 8'd1, 8'h30, 32'hf1f2_f3f4);
        add_write("alt_wr_p0_b", 8'd0, 8'hff, 32'hcafe_0001);
        add_read("alt_rd_p1_b", 8'd1, 8'h20, 32'h5a5a_f0f0);
        add_read("alt_rd_p0_b", 8'd0, 8'hff, 32'hcafe_0001);
        add_read("alt_rd_p1_c", 8'd1, 8'h30, 32'hf1f2_f3f4);
    endtask

    // Called and returns a short delay after a rising edge
    task automatic send_packet(input int idx);
        for (int b = 0; b < t_len[idx]; b++) begin
            in_beat.data = t_req[idx][(t_len[idx] - 1 - b) * 8 +: 8];
            in_beat.last = (b == t_len[idx] - 1);
            in_beat.user = (b == t_user[idx]);
            in_valid = 1'b1;
            while (!in_ready) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        in_valid = 1'b0;
    endtask

    task automatic push_expect(input int idx);
        exp_name = t_name[idx];
        exp_len = 4'(t_exp_len[idx]);
        exp_data = t_exp[idx];
        exp_push = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        exp_push = 1'b0;
    endtask

    always @(posedge clk) begin
        #DRIVE_DLY;
        out_ready = ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (n_tests != 0 && cycles > 64 * n_tests + 200) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int port;
        int drain;
        rst_n = 1'b0;
        in_beat = '0;
        // A beat offered during reset must not be taken
        in_valid = 1'b1;
        exp_push = 1'b0;
        exp_name = '0;
        exp_len = '0;
        exp_data = '0;
        end_check = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            port = int'(t_req[i][(t_len[i] - 1) * 8 +: 8]);
            // Previous responses of this port complete first
            while (port < `XFCP_PORT_COUNT && busy[port]) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            if (t_exp_len[i] != 0) begin
                push_expect(i);
            end
            send_packet(i);
        end
        drain = 0;
        while (busy != '0 && drain < 200) begin
            @(posedge clk);
            #DRIVE_DLY;
            drain++;
        end
        // Room for a stray response to show up
        repeat (20) @(posedge clk);
        #DRIVE_DLY;
        end_check = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        end_check = 1'b0;
        total = mon_errors + u_xfcp_core.u_properties.fail_cnt;
        $display("errors: %0d total, %0d response checks, %0d assertions",
                 total, mon_errors, u_xfcp_core.u_properties.fail_cnt);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/xfcp_pkg.sv
verilog/stream_skid.sv
verilog/xfcp_route.sv
verilog/xfcp_wb_access.sv
verilog/wb_ram.sv
verilog/xfcp_merge.sv
verilog/xfcp_core.sv
verification/tb_clock.sv
verification/xfcp_properties.sv
verification/xfcp_monitor.sv
verification/tb_xfcp_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --assert -Wno-fatal -f build.f --top-module tb_xfcp_core &&
./obj_dir/Vtb_xfcp_core +verilator+error+limit+100 | tee /dev/stderr |
    grep -qx "all tests passed" ||
exit 1
